// ==== design/scsi_dma_pkg.sv ====
// SCSI DMA shared types
`default_nettype none

package scsi_dma_pkg;

    typedef logic [31:0] lword_t;       // FIFO and host data word
    typedef logic [7:0]  byte_t;        // SCSI data byte

    // Wishbone classic request, held by the master until ack
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [4:0] adr;                // Byte address
        lword_t     dat;
    } wb_req_t;

    typedef struct packed {
        logic   ack;
        lword_t dat;
    } wb_rsp_t;

    // Control state machine outputs
    typedef struct packed {
        logic cpu2s;        // CPU to SCSI register write
        logic dack;         // DMA acknowledge to the chip
        logic f2s;          // FIFO to SCSI byte cycle
        logic incbo;        // Advance byte pointer
        logic incni;        // FIFO push
        logic incno;        // FIFO pop
        logic rdfifo;       // Load unpack register
        logic re;
        logic rififo;       // Load packed word
        logic s2cpu;        // SCSI to CPU register read
        logic s2f;          // SCSI to FIFO byte cycle
        logic scsi_cs;
        logic we;
        logic set_dsack;    // End of register cycle
    } sm_cmd_t;

    // Control state machine inputs, apart from the chip's DMA request
    typedef struct packed {
        logic boeq3;
        logic rdfifo_o;
        logic rififo_o;
        logic ccpureq;
        logic rw;           // 1 reads the chip
        logic cdsack_n;
        logic dmadir;       // 1 moves SCSI to FIFO
        logic fifo_empty;
        logic fifo_full;
    } sm_stat_t;

    // Pins toward the SCSI chip
    typedef struct packed {
        logic       cs;
        logic       re;
        logic       we;
        logic       dack;
        logic [1:0] adr;
        byte_t      dout;
    } scsi_out_t;

    // Host address map
    localparam logic [4:0] ADR_CTRL   = 5'h00;
    localparam logic [4:0] ADR_STATUS = 5'h04;
    localparam logic [4:0] ADR_DATA   = 5'h08;
    localparam logic [4:0] ADR_SCSI   = 5'h10;  // Chip registers 0 to 3 up to 0x1C

endpackage

`default_nettype wire

// ==== design/scsi_sm.sv ====
// SCSI control state machine
`timescale 1ns/100ps
`default_nettype none

module scsi_sm
    import scsi_dma_pkg::*;
(
    input  wire      CLK,
    input  wire      nRESET,
    input  wire      sm_stat_t stat,
    input  wire      scsi_dreq_n,   // DMA request from the chip, active low
    output sm_cmd_t  cmd
);

    typedef enum logic [4:0] {
        s0  = 5'd0,     // Idle
        s1  = 5'd1,
        s2  = 5'd2,
        s3  = 5'd3,
        s4  = 5'd4,
        s6  = 5'd6,
        s8  = 5'd8,
        s9  = 5'd9,
        s10 = 5'd10,
        s12 = 5'd12,
        s14 = 5'd14,
        s17 = 5'd17,
        s18 = 5'd18,
        s19 = 5'd19,
        s20 = 5'd20,
        s22 = 5'd22,
        s24 = 5'd24,
        s25 = 5'd25,
        s26 = 5'd26,
        s28 = 5'd28,
        s30 = 5'd30
    } state_t;

    state_t state, state_next;
    logic   word_open;      // Unpack register holds bytes still to send
    logic   s2f_ok;
    logic   f2s_ok;

    // A DMA byte may start only when the FIFO side can take or give it
    assign s2f_ok = ~scsi_dreq_n & stat.dmadir & ~stat.fifo_full & ~stat.rififo_o;
    assign f2s_ok = ~scsi_dreq_n & ~stat.dmadir & ~stat.rdfifo_o &
                    (word_open | ~stat.fifo_empty);

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state     <= s0;
            word_open <= 1'b0;
        end else begin
            state <= state_next;
            if (cmd.rdfifo) begin
                word_open <= 1'b1;
            end else if (cmd.incbo && cmd.f2s && stat.boeq3) begin
                word_open <= 1'b0;          // Last byte of the word sent
            end
        end
    end

    always_comb begin
        state_next = state;
        cmd        = '0;

        case (state)
            s0: begin
                cmd.incni = stat.rififo_o;  // Push the word packed last cycle
                if (s2f_ok) begin
                    cmd.dack   = 1'b1;
                    state_next = s24;
                end else if (f2s_ok) begin
                    cmd.dack   = 1'b1;
                    cmd.rdfifo = ~word_open;    // Fetch a new word at byte 0
                    state_next = s28;
                end else if (stat.ccpureq) begin
                    state_next = s8;
                end
            end

            // SCSI to FIFO byte
            s24, s4, s20: begin
                cmd.re     = 1'b1;
                cmd.s2f    = 1'b1;
                cmd.dack   = 1'b1;
                state_next = (state == s24) ? s4 : (state == s4) ? s20 : s12;
            end
            s12: begin
                cmd.incbo  = 1'b1;
                cmd.s2f    = 1'b1;
                cmd.rififo = stat.boeq3;
                state_next = s0;
            end

            // FIFO to SCSI byte
            s28: begin
                cmd.we     = 1'b1;
                cmd.f2s    = 1'b1;
                cmd.dack   = 1'b1;
                cmd.incno  = stat.rdfifo_o;     // Pop the word just loaded
                state_next = s2;
            end
            s2, s18: begin
                cmd.we     = 1'b1;
                cmd.f2s    = 1'b1;
                cmd.dack   = 1'b1;
                state_next = (state == s2) ? s18 : s1;
            end
            s1: begin
                cmd.f2s    = 1'b1;
                cmd.incbo  = 1'b1;
                state_next = s0;
            end

            // CPU register access
            s8: begin
                cmd.scsi_cs = 1'b1;
                if (stat.rw) begin
                    cmd.re     = 1'b1;
                    cmd.s2cpu  = 1'b1;
                    state_next = s10;
                end else begin
                    cmd.we     = 1'b1;
                    cmd.cpu2s  = 1'b1;
                    state_next = s17;
                end
            end
            s10, s30, s3: begin
                cmd.re      = 1'b1;
                cmd.s2cpu   = 1'b1;
                cmd.scsi_cs = 1'b1;
                state_next  = (state == s10) ? s30 : (state == s30) ? s3 : s19;
            end
            s19: begin
                cmd.re        = 1'b1;
                cmd.s2cpu     = 1'b1;
                cmd.scsi_cs   = 1'b1;   // Keeps read data valid at capture
                cmd.set_dsack = 1'b1;
                state_next    = s9;
            end
            s9: begin
                cmd.s2cpu  = 1'b1;
                state_next = s25;
            end
            s25: begin
                cmd.s2cpu = 1'b1;
                if (stat.cdsack_n) state_next = s0;     // Host has closed the cycle
            end
            s17, s26: begin
                cmd.we      = 1'b1;
                cmd.cpu2s   = 1'b1;
                cmd.scsi_cs = 1'b1;
                state_next  = (state == s17) ? s26 : s6;
            end
            s6: begin
                cmd.cpu2s     = 1'b1;
                cmd.scsi_cs   = 1'b1;
                cmd.set_dsack = 1'b1;
                state_next    = s22;
            end
            s22: state_next = s14;
            s14: begin
                if (stat.cdsack_n) state_next = s0;
            end

            default: state_next = s0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/dma_fifo.sv ====
// Longword FIFO
`timescale 1ns/100ps
`default_nettype none

module dma_fifo
    import scsi_dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire    CLK,
    input  wire    nRESET,
    input  wire    scsi_push,
    input  wire    lword_t scsi_wdata,
    input  wire    scsi_pop,
    output lword_t scsi_rdata,
    input  wire    host_push,
    input  wire    lword_t host_wdata,
    input  wire    host_pop,
    output lword_t host_rdata,
    output logic   empty,
    output logic   full,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    lword_t          mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr, rd_ptr;
    logic            push_en, pop_en;
    lword_t          wdata;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Only one side writes in a given direction
    assign wdata   = scsi_push ? scsi_wdata : host_wdata;
    assign push_en = (scsi_push | host_push) & ~full;
    assign pop_en  = (scsi_pop | host_pop) & ~empty;

    assign empty = (count == '0);
    assign full  = (count == CW'(FIFO_DEPTH));

    assign scsi_rdata = mem[rd_ptr];    // Head word, shown to both sides
    assign host_rdata = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (push_en) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) wr_ptr <= ptr_inc(wr_ptr);
            if (pop_en)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/byte_lane.sv ====
// Byte packing and unpacking lane
`timescale 1ns/100ps
`default_nettype none

module byte_lane
    import scsi_dma_pkg::*;
(
    input  wire    CLK,
    input  wire    nRESET,
    input  wire    sm_cmd_t cmd,
    input  wire    byte_t din,
    input  wire    lword_t fifo_rdata,
    output lword_t pack_word,
    output byte_t  dout,
    output logic   boeq3,
    output logic   rififo_o,
    output logic   rdfifo_o
);

    logic [1:0] bo;             // Byte pointer, byte 0 is most significant
    logic [4:0] lane_sel;       // Bit offset of the current byte
    lword_t     pack_sr;        // Word being assembled from the chip
    lword_t     unpack;         // Word being sent to the chip

    assign boeq3    = (bo == 2'd3);
    assign lane_sel = {~bo, 3'b000};
    assign dout     = unpack[lane_sel +: 8];

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            bo       <= 2'd0;
            rififo_o <= 1'b0;
            rdfifo_o <= 1'b0;
        end else begin
            if (cmd.incbo) bo <= bo + 2'd1;

            if (cmd.rififo) begin
                rififo_o <= 1'b1;
            end else if (cmd.incni) begin
                rififo_o <= 1'b0;       // Word now pushed
            end

            if (cmd.rdfifo) begin
                rdfifo_o <= 1'b1;
            end else if (cmd.incno) begin
                rdfifo_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        // Written in every strobe cycle, so the final one decides
        if (cmd.s2f && cmd.re) pack_sr[lane_sel +: 8] <= din;
        if (cmd.rififo) pack_word <= pack_sr;
        if (cmd.rdfifo) unpack <= fifo_rdata;
    end

endmodule

`default_nettype wire

// ==== design/host_port.sv ====
// Wishbone host port
`timescale 1ns/100ps
`default_nettype none

module host_port
    import scsi_dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire     CLK,
    input  wire     nRESET,
    input  wire     wb_req_t wb_i,
    output wb_rsp_t wb_o,
    input  wire     sm_cmd_t cmd,
    input  wire     byte_t scsi_din,
    input  wire     empty,
    input  wire     full,
    input  wire     [$clog2(FIFO_DEPTH+1)-1:0] count,
    input  wire     lword_t host_rdata,
    output logic    host_push,
    output logic    host_pop,
    output logic    ccpureq,
    output logic    rw,
    output logic    cdsack_n,
    output logic    dmadir,
    output logic [1:0] reg_adr,
    output byte_t   reg_wdata
);

    logic   req;
    logic   ctrl_sel, stat_sel, data_sel, win_sel;
    logic   win_req;
    logic   reg_done;       // CTRL, STATUS or unmapped access
    logic   dsack_evt;
    logic   ack_q;
    lword_t rsp_dat;
    lword_t status_word;
    lword_t misc_rdata;

    assign req      = wb_i.cyc & wb_i.stb;
    assign win_sel  = ({wb_i.adr[4], 4'b0000} == ADR_SCSI);
    assign ctrl_sel = (wb_i.adr[4:2] == ADR_CTRL[4:2]);
    assign stat_sel = (wb_i.adr[4:2] == ADR_STATUS[4:2]);
    assign data_sel = (wb_i.adr[4:2] == ADR_DATA[4:2]);

    assign reg_done  = req & ~win_sel & ~data_sel & ~ack_q;
    assign host_push = req & data_sel & wb_i.we & ~full & ~ack_q;    // Waits while full
    assign host_pop  = req & data_sel & ~wb_i.we & ~empty & ~ack_q;  // Waits while empty

    // Register window toward the state machine
    assign win_req   = req & win_sel;
    assign ccpureq   = win_req & cdsack_n;
    assign rw        = ~wb_i.we;
    assign reg_adr   = wb_i.adr[3:2];
    assign reg_wdata = wb_i.dat[7:0];
    assign dsack_evt = cmd.set_dsack & win_req;

    // Count starts at bit 4
    assign status_word = (lword_t'(count) << 4) | {30'b0, full, empty};

    always_comb begin
        if (stat_sel) begin
            misc_rdata = status_word;
        end else if (ctrl_sel) begin
            misc_rdata = {31'b0, dmadir};
        end else begin
            misc_rdata = '0;
        end
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            ack_q    <= 1'b0;
            dmadir   <= 1'b0;
            cdsack_n <= 1'b1;
        end else begin
            ack_q <= reg_done | host_push | host_pop | dsack_evt;
            if (reg_done && ctrl_sel && wb_i.we) dmadir <= wb_i.dat[0];
            if (dsack_evt) begin
                cdsack_n <= 1'b0;
            end else if (!win_req) begin
                cdsack_n <= 1'b1;       // Master has dropped the strobe
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (host_pop) begin
            rsp_dat <= host_rdata;
        end else if (dsack_evt && rw) begin
            rsp_dat <= {24'b0, scsi_din};   // Chip register in the low byte
        end else if (reg_done) begin
            rsp_dat <= misc_rdata;
        end
    end

    assign wb_o = '{ack: ack_q, dat: rsp_dat};

endmodule

`default_nettype wire

// ==== design/scsi_dma_top.sv ====
// SCSI DMA controller top level
`timescale 1ns/100ps
`default_nettype none

module scsi_dma_top
    import scsi_dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  wire       CLK,
    input  wire       nRESET,
    input  wire       wb_req_t wb_i,
    output wb_rsp_t   wb_o,
    input  wire       scsi_dreq_n,
    input  wire       byte_t scsi_din,
    output scsi_out_t scsi_o
);

    sm_cmd_t    cmd;
    sm_stat_t   stat;
    lword_t     pack_word;
    lword_t     fifo_rdata;
    lword_t     host_rdata;
    byte_t      lane_dout;
    byte_t      reg_wdata;
    logic [1:0] reg_adr;
    logic       boeq3, rififo_o, rdfifo_o;
    logic       ccpureq, rw, cdsack_n, dmadir;
    logic       empty, full;
    logic       host_push, host_pop;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;

    assign stat = '{boeq3: boeq3, rdfifo_o: rdfifo_o, rififo_o: rififo_o,
                    ccpureq: ccpureq, rw: rw, cdsack_n: cdsack_n, dmadir: dmadir,
                    fifo_empty: empty, fifo_full: full};

    // Register writes drive the host byte, DMA drives the lane byte
    assign scsi_o = '{cs: cmd.scsi_cs, re: cmd.re, we: cmd.we, dack: cmd.dack,
                      adr: reg_adr, dout: cmd.cpu2s ? reg_wdata : lane_dout};

    scsi_sm u_sm (
        .CLK(CLK), .nRESET(nRESET), .stat(stat), .scsi_dreq_n(scsi_dreq_n), .cmd(cmd)
    );

    dma_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .CLK(CLK), .nRESET(nRESET),
        .scsi_push(cmd.incni), .scsi_wdata(pack_word),
        .scsi_pop(cmd.incno), .scsi_rdata(fifo_rdata),
        .host_push(host_push), .host_wdata(wb_i.dat),
        .host_pop(host_pop), .host_rdata(host_rdata),
        .empty(empty), .full(full), .count(count)
    );

    byte_lane u_lane (
        .CLK(CLK), .nRESET(nRESET), .cmd(cmd), .din(scsi_din),
        .fifo_rdata(fifo_rdata), .pack_word(pack_word), .dout(lane_dout),
        .boeq3(boeq3), .rififo_o(rififo_o), .rdfifo_o(rdfifo_o)
    );

    host_port #(.FIFO_DEPTH(FIFO_DEPTH)) u_host (
        .CLK(CLK), .nRESET(nRESET), .wb_i(wb_i), .wb_o(wb_o), .cmd(cmd),
        .scsi_din(scsi_din), .empty(empty), .full(full), .count(count),
        .host_rdata(host_rdata), .host_push(host_push), .host_pop(host_pop),
        .ccpureq(ccpureq), .rw(rw), .cdsack_n(cdsack_n), .dmadir(dmadir),
        .reg_adr(reg_adr), .reg_wdata(reg_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/scsi_chip_model.sv ====
// Behavioral SCSI chip
`timescale 1ns/100ps
`default_nettype none

module scsi_chip_model
    import scsi_dma_pkg::*;
(
    input  wire       CLK,
    input  wire       nRESET,
    input  wire       scsi_out_t pins,
    output logic      dreq_n,
    output byte_t     din
);

    byte_t      regs [4];           // Chip registers 0 to 3
    byte_t      src_mem [256];      // Source queue toward the FIFO
    byte_t      sink_mem [256];     // Sink queue from the FIFO
    logic [7:0] src_fill = '0;      // Staged bytes, not yet offered
    logic [7:0] src_wr = '0;
    logic [7:0] src_rd;
    logic [7:0] sink_want = '0;
    logic [7:0] sink_cnt;
    logic       rd_burst, wr_burst;
    logic       dma_rd, dma_wr;
    byte_t      wr_byte;

    assign dma_rd = pins.dack & pins.re & ~pins.cs;
    assign dma_wr = pins.dack & pins.we & ~pins.cs;

    // Request while a byte is waiting or the sink still wants one
    assign dreq_n = ~((src_rd != src_wr) | (sink_cnt < sink_want));

    always_comb begin
        if (pins.cs && pins.re) begin
            din = regs[pins.adr];
        end else if (src_rd != src_wr) begin
            din = src_mem[src_rd];      // Head of the source queue
        end else begin
            din = '0;
        end
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            src_rd   <= '0;
            sink_cnt <= '0;
            rd_burst <= 1'b0;
            wr_burst <= 1'b0;
            wr_byte  <= '0;
        end else begin
            rd_burst <= dma_rd;
            wr_burst <= dma_wr;
            if (dma_wr) wr_byte <= pins.dout;
            if (rd_burst && !dma_rd) src_rd <= src_rd + 8'd1;     // Strobe over, byte taken
            if (wr_burst && !dma_wr) sink_cnt <= sink_cnt + 8'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (pins.cs && pins.we) regs[pins.adr] <= pins.dout;
        if (wr_burst && !dma_wr) sink_mem[sink_cnt] <= wr_byte;   // Last byte seen with we
    end

    task automatic stage_byte(input byte_t b);
        src_mem[src_fill] = b;
        src_fill = src_fill + 8'd1;
    endtask

    task automatic release_bytes();
        src_wr <= src_fill;
    endtask

    task automatic accept_bytes(input logic [7:0] n);
        sink_want <= sink_want + n;
    endtask

endmodule

`default_nettype wire

// ==== tests/scsi_sm_asserts.sv ====
// Control state machine assertions
`timescale 1ns/100ps
`default_nettype none

module scsi_sm_asserts
    import scsi_dma_pkg::*;
(
    input wire          CLK,
    input wire          nRESET,
    input wire sm_cmd_t cmd
);

    // Chip strobes are exclusive
    strobes_exclusive: assert property (@(posedge CLK) disable iff (!nRESET)
        !(cmd.re && cmd.we))
        else $error("re and we are high in the same cycle");

    // A push needs a word packed in the cycle before
    push_after_pack: assert property (@(posedge CLK) disable iff (!nRESET)
        cmd.incni |-> $past(cmd.rififo))
        else $error("incni without rififo in the previous cycle");

    dack_without_cs: assert property (@(posedge CLK) disable iff (!nRESET)
        !(cmd.dack && cmd.scsi_cs))
        else $error("dack and scsi_cs are high in the same cycle");

endmodule

bind scsi_sm scsi_sm_asserts u_sm_asserts (.CLK(CLK), .nRESET(nRESET), .cmd(cmd));

`default_nettype wire

// ==== tests/scsi_dma_tb.sv ====
// SCSI DMA controller testbench
`timescale 1ns/100ps
`default_nettype none

module scsi_dma_tb
    import scsi_dma_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int CLK_HALF   = 50;
    localparam int MAX_CYCLES = 20000;  // About 112 DMA bytes plus host traffic, wide margin

    logic      CLK;
    logic      nRESET;
    wb_req_t   wb_i;
    wb_rsp_t   wb_o;
    logic      scsi_dreq_n;
    byte_t     scsi_din;
    scsi_out_t scsi_o;
    logic [31:0] rng;
    int        errors;
    byte_t     sent [256];      // Bytes handed to the chip source

    scsi_dma_top #(.FIFO_DEPTH(FIFO_DEPTH)) UUT (
        .CLK(CLK), .nRESET(nRESET), .wb_i(wb_i), .wb_o(wb_o),
        .scsi_dreq_n(scsi_dreq_n), .scsi_din(scsi_din), .scsi_o(scsi_o)
    );

    scsi_chip_model chip (
        .CLK(CLK), .nRESET(nRESET), .pins(scsi_o), .dreq_n(scsi_dreq_n), .din(scsi_din)
    );

    initial begin
        CLK = 1'b0;
        forever #CLK_HALF CLK = ~CLK;
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge CLK);
        $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Checks failed");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Byte 0 lands in bits 31:24
    function automatic lword_t big_endian_word(input int first);
        return {sent[8'(first)], sent[8'(first + 1)], sent[8'(first + 2)], sent[8'(first + 3)]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic wait_ack();
        do @(negedge CLK); while (!wb_o.ack);
    endtask

    task automatic wb_write(input logic [4:0] adr, input lword_t dat);
        @(posedge CLK);
        wb_i <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        wait_ack();
        @(posedge CLK);
        wb_i <= '0;
    endtask

    task automatic wb_read(input logic [4:0] adr, output lword_t dat);
        @(posedge CLK);
        wb_i <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
        wait_ack();
        dat = wb_o.dat;
        @(posedge CLK);
        wb_i <= '0;
    endtask

    // Random bytes into the chip source, offered all at once
    task automatic feed_source(input int n);
        @(posedge CLK);
        for (int i = 0; i < n; i++) begin
            rng = xorshift(rng);
            sent[8'(i)] = rng[7:0];
            chip.stage_byte(rng[7:0]);
        end
        chip.release_bytes();
    endtask

    task automatic read_words(input int n);
        lword_t d;
        for (int w = 0; w < n; w++) begin
            wb_read(ADR_DATA, d);
            check_value($sformatf("wb_o.dat word %0d", w), d, big_endian_word(4 * w));
        end
    endtask

    task automatic reset_state();
        lword_t d;
        check_value("scsi_o cs/re/we/dack",
                    {28'b0, scsi_o.cs, scsi_o.re, scsi_o.we, scsi_o.dack}, 32'h0);
        check_value("wb_o.ack", {31'b0, wb_o.ack}, 32'h0);
        wb_read(ADR_STATUS, d);
        check_value("STATUS", d, 32'h1);   // Empty, count 0
        wb_read(ADR_CTRL, d);
        check_value("CTRL", d, 32'h0);
    endtask

    task automatic register_window();
        lword_t d;
        byte_t  vals [4];
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            vals[2'(i)] = rng[7:0];
            wb_write(ADR_SCSI | 5'(i * 4), {24'b0, rng[7:0]});
        end
        for (int i = 0; i < 4; i++) begin
            wb_read(ADR_SCSI | 5'(i * 4), d);
            check_value($sformatf("wb_o.dat SCSI reg %0d", i), d, {24'b0, vals[2'(i)]});
            check_value($sformatf("chip reg %0d", i), {24'b0, chip.regs[2'(i)]},
                        {24'b0, vals[2'(i)]});
        end
    endtask

    task automatic scsi_to_fifo();
        lword_t d;
        wb_write(ADR_CTRL, 32'h1);
        wb_read(ADR_CTRL, d);
        check_value("CTRL", d, 32'h1);
        feed_source(16);
        read_words(4);
        wb_read(ADR_STATUS, d);
        check_value("STATUS", d, 32'h1);
    endtask

    task automatic fifo_to_scsi();
        lword_t words [4];
        lword_t exp;
        wb_write(ADR_CTRL, 32'h0);
        chip.accept_bytes(8'd16);
        for (int w = 0; w < 4; w++) begin
            rng = xorshift(rng);
            words[2'(w)] = rng;
            wb_write(ADR_DATA, rng);
        end
        do @(negedge CLK); while (chip.sink_cnt != 8'd16);
        for (int i = 0; i < 16; i++) begin
            exp = (words[2'(i / 4)] >> (8 * (3 - i % 4))) & 32'hFF;    // MSB first
            check_value($sformatf("chip sink byte %0d", i), {24'b0, chip.sink_mem[8'(i)]}, exp);
        end
    endtask

    task automatic back_pressure();
        lword_t d;
        wb_write(ADR_CTRL, 32'h1);
        feed_source(40);
        do begin
            wb_read(ADR_STATUS, d);
        end while (d[1] == 1'b0);
        check_value("STATUS", d, (32'(FIFO_DEPTH) << 4) | 32'h2);
        read_words(10);
        wb_read(ADR_STATUS, d);
        check_value("STATUS", d, 32'h1);
    endtask

    task automatic access_during_dma();
        lword_t d;
        byte_t  v;
        feed_source(40);
        rng = xorshift(rng);
        v = rng[7:0];
        wb_write(ADR_SCSI | 5'h08, {24'b0, v});     // Chip register 2
        wb_read(ADR_SCSI | 5'h08, d);
        check_value("wb_o.dat SCSI reg 2", d, {24'b0, v});
        check_value("chip reg 2", {24'b0, chip.regs[2]}, {24'b0, v});
        read_words(10);
    endtask

    initial begin
        errors = 0;
        rng    = 32'd16;
        nRESET = 1'b0;
        wb_i   = '0;
        repeat (2) @(posedge CLK);
        nRESET <= 1'b1;
        @(negedge CLK);
        reset_state();
        register_window();
        scsi_to_fifo();
        fifo_to_scsi();
        back_pressure();
        access_during_dma();
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/scsi_dma_pkg.sv
design/scsi_sm.sv
design/dma_fifo.sv
design/byte_lane.sv
design/host_port.sv
design/scsi_dma_top.sv
tests/scsi_chip_model.sv
tests/scsi_sm_asserts.sv
tests/scsi_dma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SCSI DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module scsi_dma_tb -o scsi_dma_sim \
    || { echo "Build failed"; exit 1; }
out="$(./obj_dir/scsi_dma_sim 2>&1)"
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
